// ==== src/memPkg.sv ====
package memPkg;

    // bank geometry
    localparam int dataDepth  = 1024;
    localparam int instrDepth = 512;

    localparam int readGap = 2;                 // header to first data word on the ext bus

    // AXI4-Lite register map
    localparam logic [3:0] regExtAddr  = 4'h0;
    localparam logic [3:0] regSramAddr = 4'h4;
    localparam logic [3:0] regLen      = 4'h8;
    localparam logic [3:0] regCtrl     = 4'hC;

    // regCtrl fields
    localparam int ctrlStart   = 0;             // write side
    localparam int ctrlToExt   = 1;
    localparam int ctrlCacheId = 2;
    localparam int ctrlBusy    = 0;             // read side
    localparam int progressLsb = 16;

    localparam logic [1:0] respOkay   = 2'b00;
    localparam logic [1:0] respSlvErr = 2'b10;

    typedef logic [31:0] dataWord_t;
    typedef logic [63:0] instrWord_t;

    typedef struct packed {
        logic        ce;
        logic        we;
        logic [3:0]  wm;                        // byte mask
        logic [29:0] addr;                      // 32-bit word address
        logic [31:0] data;
    } cacheIf_t;

    typedef struct packed {
        logic [29:0] extAddr;
        logic [9:0]  sramAddr;
        logic [10:0] len;                       // 1 to 1024 words
        logic        toExt;
        logic        cacheId;                   // 0 data bank, 1 instruction bank
    } xferCmd_t;

    typedef struct packed {
        logic        awvalid;
        logic [3:0]  awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
        logic        arvalid;
        logic [3:0]  araddr;
        logic        rready;
    } axiReq_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axiRsp_t;

endpackage

// ==== src/ctrlRegs.sv ====
`timescale 1ns/1ps

module ctrlRegs (
    input  logic             SPI_clk,
    input  logic             rstN,
    input  memPkg::axiReq_t  axiReq,
    output memPkg::axiRsp_t  axiRsp,
    input  logic             busy,
    input  logic [9:0]       progress,
    output logic             start,
    output memPkg::xferCmd_t cmd
);
    import memPkg::*;

    logic [29:0] extAddrQ;
    logic [9:0]  sramAddrQ;
    logic [10:0] lenQ;
    logic        toExtQ;
    logic        cacheIdQ;
    xferCmd_t    cmdQ;

    logic        bvalidQ;
    logic [1:0]  brespQ;
    logic        rvalidQ;
    logic [31:0] rdataQ;

    logic        wrAcc;
    logic        rdAcc;
    logic [3:0]  wrOff;
    logic [3:0]  rdOff;
    logic        startReq;
    logic        startBad;
    logic [31:0] extAddrNew;
    logic [31:0] sramAddrNew;
    logic [31:0] lenNew;
    logic [31:0] rdMux;

    function automatic logic [31:0] applyStrb(input logic [31:0] old, input logic [31:0] wdata,
                                              input logic [3:0] strb);
        logic [31:0] mask;
        for (int i = 0; i < 4; i++) begin
            mask[i*8 +: 8] = {8{strb[i]}};
        end
        return (old & ~mask) | (wdata & mask);
    endfunction

    assign wrAcc = axiReq.awvalid && axiReq.wvalid && !bvalidQ;     // one write in flight
    assign rdAcc = axiReq.arvalid && !rvalidQ;
    assign wrOff = {axiReq.awaddr[3:2], 2'b00};
    assign rdOff = {axiReq.araddr[3:2], 2'b00};

    assign startReq = wrAcc && wrOff == regCtrl && axiReq.wstrb[0] && axiReq.wdata[ctrlStart];
    assign startBad = startReq && (busy || (axiReq.wdata[ctrlToExt] && axiReq.wdata[ctrlCacheId]));
    assign start    = startReq && !startBad;

    assign extAddrNew  = applyStrb({2'b0, extAddrQ}, axiReq.wdata, axiReq.wstrb);
    assign sramAddrNew = applyStrb({22'b0, sramAddrQ}, axiReq.wdata, axiReq.wstrb);
    assign lenNew      = applyStrb({21'b0, lenQ}, axiReq.wdata, axiReq.wstrb);

    always_ff @(posedge SPI_clk or negedge rstN) begin
        if (!rstN) begin
            bvalidQ   <= 1'b0;
            rvalidQ   <= 1'b0;
            extAddrQ  <= '0;
            sramAddrQ <= '0;
            lenQ      <= '0;
            toExtQ    <= 1'b0;
            cacheIdQ  <= 1'b0;
        end else begin
            if (wrAcc) begin
                bvalidQ <= 1'b1;
            end else if (axiReq.bready) begin
                bvalidQ <= 1'b0;
            end
            if (rdAcc) begin
                rvalidQ <= 1'b1;
            end else if (axiReq.rready) begin
                rvalidQ <= 1'b0;
            end
            if (wrAcc && !startBad) begin
                case (wrOff)
                    regExtAddr:  extAddrQ  <= extAddrNew[29:0];
                    regSramAddr: sramAddrQ <= sramAddrNew[9:0];
                    regLen:      lenQ      <= lenNew[10:0];
                    default: begin
                        if (axiReq.wstrb[0]) begin
                            toExtQ   <= axiReq.wdata[ctrlToExt];
                            cacheIdQ <= axiReq.wdata[ctrlCacheId];
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge SPI_clk) begin
        if (wrAcc) begin
            brespQ <= startBad ? respSlvErr : respOkay;
        end
        if (rdAcc) begin
            rdataQ <= rdMux;
        end
        if (start) begin
            cmdQ <= '{extAddr: extAddrQ, sramAddr: sramAddrQ, len: lenQ,
                      toExt: axiReq.wdata[ctrlToExt], cacheId: axiReq.wdata[ctrlCacheId]};
        end
    end

    always_comb begin
        rdMux = '0;
        case (rdOff)
            regExtAddr:  rdMux[29:0] = extAddrQ;
            regSramAddr: rdMux[9:0]  = sramAddrQ;
            regLen:      rdMux[10:0] = lenQ;
            default: begin
                rdMux[ctrlBusy]          = busy;
                rdMux[ctrlToExt]         = toExtQ;
                rdMux[ctrlCacheId]       = cacheIdQ;
                rdMux[progressLsb +: 10] = progress;
            end
        endcase
    end

    always_comb begin
        axiRsp.awready = wrAcc;
        axiRsp.wready  = wrAcc;
        axiRsp.bvalid  = bvalidQ;
        axiRsp.bresp   = brespQ;
        axiRsp.arready = rdAcc;
        axiRsp.rvalid  = rvalidQ;
        axiRsp.rdata   = rdataQ;
        axiRsp.rresp   = respOkay;
    end

    assign cmd = cmdQ;

    assert property (@(posedge SPI_clk) disable iff (!rstN) bvalidQ && !axiReq.bready |=> bvalidQ)
        else $error("bvalid dropped before bready");

endmodule

// ==== src/transferFsm.sv ====
`timescale 1ns/1ps

module transferFsm (
    input  logic              SPI_clk,
    input  logic              rstN,
    input  logic              start,
    input  memPkg::xferCmd_t  cmd,
    input  logic              last,
    input  logic [9:0]        offset,
    output logic              step,
    output logic              busy,
    output memPkg::cacheIf_t  bankAcc,
    output logic              bankSel,
    input  memPkg::dataWord_t bankRdData,
    output logic              extEn,
    output logic              extOen,
    output logic [31:0]       extBusOut,
    input  logic [31:0]       extBusIn
);
    import memPkg::*;

    typedef enum logic [2:0] {sIdle, sHeader, sGap, sStream, sDone} state_t;

    localparam int gapW = $clog2(readGap) + 1;

    state_t          state;
    state_t          stateNext;
    logic [gapW-1:0] gapCnt;
    logic            gapEnd;
    logic [9:0]      wrOff;
    logic [9:0]      rdOff;

    assign gapEnd = state == sGap && gapCnt == '0;

    always_comb begin
        stateNext = state;
        case (state)
            sIdle:   if (start) stateNext = sHeader;
            sHeader: stateNext = sGap;
            sGap:    if (gapCnt == '0) stateNext = sStream;
            sStream: if (last) stateNext = sDone;
            default: stateNext = sIdle;
        endcase
    end

    always_ff @(posedge SPI_clk or negedge rstN) begin
        if (!rstN) begin
            state  <= sIdle;
            gapCnt <= '0;
        end else begin
            state <= stateNext;
            if (state == sHeader) begin
                gapCnt <= gapW'(readGap - 2);       // header cycle counts toward the gap
            end else if (state == sGap) begin
                gapCnt <= gapCnt - 1'b1;
            end
        end
    end

    assign busy    = state != sIdle;
    assign step    = state == sStream;
    assign bankSel = cmd.cacheId;
    assign extEn   = state inside {sHeader, sGap, sStream};
    assign extOen  = state == sHeader || (state == sStream && cmd.toExt);

    always_comb begin
        extBusOut = '0;
        if (state == sHeader) begin
            extBusOut = {cmd.toExt, 1'b0, cmd.extAddr};
        end else if (state == sStream && cmd.toExt) begin
            extBusOut = bankRdData;
        end
    end

    // reads run one word ahead to cover the bank latency
    assign wrOff = cmd.sramAddr + offset;
    assign rdOff = cmd.sramAddr + (state == sStream ? offset + 10'd1 : 10'd0);

    always_comb begin
        bankAcc    = '0;
        bankAcc.wm = 4'hF;                          // instruction bank selects the half by addr[0]
        if (cmd.toExt) begin
            bankAcc.ce   = gapEnd || (state == sStream && !last);
            bankAcc.addr = 30'(rdOff);
        end else begin
            bankAcc.ce   = state == sStream;
            bankAcc.we   = state == sStream;
            bankAcc.addr = 30'(wrOff);
            bankAcc.data = extBusIn;
        end
    end

    assert property (@(posedge SPI_clk) disable iff (!rstN) state == sStream && !last |=> extEn)
        else $error("extEn fell inside a burst");

endmodule

// ==== src/burstCounter.sv ====
`timescale 1ns/1ps

module burstCounter (
    input  logic                                 SPI_clk,
    input  logic                                 rstN,
    input  logic                                 start,
    input  logic                                 step,
    input  logic [$clog2(memPkg::dataDepth):0]   len,
    output logic [$clog2(memPkg::dataDepth)-1:0] offset,
    output logic                                 last,
    output logic [$clog2(memPkg::dataDepth)-1:0] progress
);
    logic [$clog2(memPkg::dataDepth)-1:0] offsetQ;
    logic [$clog2(memPkg::dataDepth)-1:0] progressQ;

    always_ff @(posedge SPI_clk or negedge rstN) begin
        if (!rstN) begin
            offsetQ   <= '0;
            progressQ <= '0;
        end else if (start) begin
            offsetQ   <= '0;
            progressQ <= '0;
        end else if (step) begin
            offsetQ   <= offsetQ + 1'b1;
            progressQ <= progressQ + 1'b1;        // words done so far
        end
    end

    assign offset   = offsetQ;
    assign progress = progressQ;
    assign last     = {1'b0, offsetQ} == len - 1'b1;

endmodule

// ==== src/sramBank.sv ====
`timescale 1ns/1ps

module sramBank #(
    parameter type wordT = memPkg::dataWord_t,
    parameter int  depth = memPkg::dataDepth
) (
    input  logic                     SPI_clk,
    input  memPkg::cacheIf_t         portA,
    output wordT                     rdDataA,
    input  logic                     rdEnB,
    input  logic [$clog2(depth)-1:0] rdAddrB,
    output wordT                     rdDataB
);
    localparam int wordBits = $bits(wordT);
    localparam int lanes    = wordBits / 32;     // 32-bit halves per row
    localparam int laneBits = $clog2(lanes);
    localparam int rowBits  = $clog2(depth);

    wordT                  mem [depth];
    logic [29:0]           rowFull;
    logic [rowBits-1:0]    rowA;
    logic [wordBits/8-1:0] byteEn;
    wordT                  wrWord;

    assign rowFull = portA.addr >> laneBits;
    assign rowA    = rowFull[rowBits-1:0];
    assign wrWord  = {lanes{portA.data}};

    // low address bits pick the lane, wm applies inside it
    always_comb begin
        for (int l = 0; l < lanes; l++) begin
            byteEn[l*4 +: 4] = (portA.addr % lanes == l) ? portA.wm : 4'b0;
        end
    end

    always_ff @(posedge SPI_clk) begin
        if (portA.ce) begin
            if (portA.we) begin
                for (int b = 0; b < wordBits / 8; b++) begin
                    if (byteEn[b]) begin
                        mem[rowA][b*8 +: 8] <= wrWord[b*8 +: 8];
                    end
                end
            end else begin
                rdDataA <= mem[rowA];
            end
        end
        if (rdEnB) begin
            rdDataB <= mem[rdAddrB];
        end
    end

    assert property (@(posedge SPI_clk) portA.ce |-> rowFull < depth)
        else $error("port A access beyond bank depth");

endmodule

// ==== src/memSubsystem.sv ====
`timescale 1ns/1ps

module memSubsystem (
    input  logic                                  SPI_clk,
    input  logic                                  rstN,
    input  memPkg::axiReq_t                       axiReq,
    output memPkg::axiRsp_t                       axiRsp,
    output logic                                  extEn,
    output logic                                  extOen,
    output logic [31:0]                           extBusOut,
    input  logic [31:0]                           extBusIn,
    input  memPkg::cacheIf_t                      coreWr,
    input  logic                                  coreRdEn,
    input  logic [$clog2(memPkg::dataDepth)-1:0]  coreRdAddr,
    output memPkg::dataWord_t                     coreRdData,
    input  logic                                  coreFetchEn,
    input  logic [$clog2(memPkg::instrDepth)-1:0] coreFetchAddr,
    output memPkg::instrWord_t                    coreFetchData
);
    import memPkg::*;

    logic       start;
    logic       busy;
    logic       step;
    logic       last;
    logic       bankSel;
    xferCmd_t   cmd;
    logic [9:0] offset;
    logic [9:0] progress;
    cacheIf_t   bankAcc;
    cacheIf_t   coreWrA;
    cacheIf_t   dataPortA;
    cacheIf_t   instrPortA;
    dataWord_t  dataRdA;
    logic       dataOwned;
    logic       instrOwned;

    ctrlRegs u_ctrlRegs (
        .SPI_clk  (SPI_clk),
        .rstN     (rstN),
        .axiReq   (axiReq),
        .axiRsp   (axiRsp),
        .busy     (busy),
        .progress (progress),
        .start    (start),
        .cmd      (cmd)
    );

    transferFsm u_transferFsm (
        .SPI_clk    (SPI_clk),
        .rstN       (rstN),
        .start      (start),
        .cmd        (cmd),
        .last       (last),
        .offset     (offset),
        .step       (step),
        .busy       (busy),
        .bankAcc    (bankAcc),
        .bankSel    (bankSel),
        .bankRdData (dataRdA),
        .extEn      (extEn),
        .extOen     (extOen),
        .extBusOut  (extBusOut),
        .extBusIn   (extBusIn)
    );

    burstCounter u_burstCounter (
        .SPI_clk  (SPI_clk),
        .rstN     (rstN),
        .start    (start),
        .step     (step),
        .len      (cmd.len),
        .offset   (offset),
        .last     (last),
        .progress (progress)
    );

    assign dataOwned  = busy && !bankSel;
    assign instrOwned = busy && bankSel;

    // port A ownership, core writes are dropped while a transfer holds the bank
    always_comb begin
        coreWrA    = coreWr;
        coreWrA.ce = coreWr.ce && !dataOwned && coreWr.addr < 30'(dataDepth);
        dataPortA  = dataOwned ? bankAcc : coreWrA;
        instrPortA = instrOwned ? bankAcc : '0;
    end

    sramBank #(.wordT(dataWord_t), .depth(dataDepth)) u_dataBank (
        .SPI_clk (SPI_clk),
        .portA   (dataPortA),
        .rdDataA (dataRdA),
        .rdEnB   (coreRdEn),
        .rdAddrB (coreRdAddr),
        .rdDataB (coreRdData)
    );

    sramBank #(.wordT(instrWord_t), .depth(instrDepth)) u_instrBank (
        .SPI_clk (SPI_clk),
        .portA   (instrPortA),
        .rdDataA (),                                // fill only, nothing reads back
        .rdEnB   (coreFetchEn),
        .rdAddrB (coreFetchAddr),
        .rdDataB (coreFetchData)
    );

endmodule

// ==== test/extMemModel.sv ====
`timescale 1ns/1ps

module extMemModel #(
    parameter int words = 4096
) (
    input  logic        SPI_clk,
    input  logic        rstN,
    input  logic        extEn,
    input  logic        extOen,
    input  logic [31:0] extBusOut,
    output logic [31:0] extBusIn
);
    import memPkg::*;

    localparam int idxBits = $clog2(words);

    logic [31:0]        mem [words];
    logic               active;
    logic               toExt;
    logic [idxBits-1:0] base;
    int unsigned        cyc;                    // cycles since the header
    logic [idxBits-1:0] idx;

    function automatic logic [31:0] fillWord(input int unsigned a);
        return (a * 32'h9E3779B1) ^ 32'hC3A50F1E;
    endfunction

    assign idx      = base + idxBits'(cyc - readGap);
    assign extBusIn = (active && !toExt && cyc >= readGap) ? mem[idx] : '0;

    always_ff @(posedge SPI_clk or negedge rstN) begin
        if (!rstN) begin
            active <= 1'b0;
            toExt  <= 1'b0;
            base   <= '0;
            cyc    <= 0;
            for (int i = 0; i < words; i++) begin
                mem[i] <= fillWord(i);
            end
        end else if (!active) begin
            if (extEn && extOen) begin              // header word
                active <= 1'b1;
                toExt  <= extBusOut[31];
                base   <= extBusOut[idxBits-1:0];
                cyc    <= 1;
            end
        end else if (!extEn) begin
            active <= 1'b0;
        end else begin
            if (toExt && cyc >= readGap) begin
                mem[idx] <= extBusOut;
            end
            cyc <= cyc + 1;
        end
    end

endmodule

// ==== test/tbMemSubsystem.sv ====
`timescale 1ns/1ps

module tbMemSubsystem;
    import memPkg::*;

    localparam int extWords   = 4096;
    localparam int maskWrites = 16;

    logic        SPI_clk;
    logic        rstN;
    axiReq_t     axiReq;
    axiRsp_t     axiRsp;
    logic        extEn;
    logic        extOen;
    logic [31:0] extBusOut;
    logic [31:0] extBusIn;
    cacheIf_t    coreWr;
    logic        coreRdEn;
    logic [9:0]  coreRdAddr;
    dataWord_t   coreRdData;
    logic        coreFetchEn;
    logic [8:0]  coreFetchAddr;
    instrWord_t  coreFetchData;

    dataWord_t   expData  [dataDepth];
    dataWord_t   expInstr [2*instrDepth];       // 32-bit halves, even index is the low half
    dataWord_t   expExt   [extWords];

    int unsigned cycleNo;
    int unsigned busyRun;
    int unsigned lastBusyRun;
    int unsigned budget;
    logic        rdPend;
    logic [9:0]  rdPendAddr;
    logic        fetchPend;
    logic [8:0]  fetchPendAddr;

    logic [29:0] ext2;
    logic [29:0] ext3;
    logic [29:0] ext4;
    logic [29:0] ext5;
    logic [9:0]  sram2;
    logic [9:0]  sram3;
    logic [9:0]  sram5;
    int          len2;
    int          len3;
    int          len5;

    memSubsystem u_memSubsystem (
        .SPI_clk       (SPI_clk),
        .rstN          (rstN),
        .axiReq        (axiReq),
        .axiRsp        (axiRsp),
        .extEn         (extEn),
        .extOen        (extOen),
        .extBusOut     (extBusOut),
        .extBusIn      (extBusIn),
        .coreWr        (coreWr),
        .coreRdEn      (coreRdEn),
        .coreRdAddr    (coreRdAddr),
        .coreRdData    (coreRdData),
        .coreFetchEn   (coreFetchEn),
        .coreFetchAddr (coreFetchAddr),
        .coreFetchData (coreFetchData)
    );

    extMemModel #(.words(extWords)) u_extMem (
        .SPI_clk   (SPI_clk),
        .rstN      (rstN),
        .extEn     (extEn),
        .extOen    (extOen),
        .extBusOut (extBusOut),
        .extBusIn  (extBusIn)
    );

    always #4 SPI_clk = ~SPI_clk;

    function automatic dataWord_t extFill(input int unsigned a);
        return (a * 32'h9E3779B1) ^ 32'hC3A50F1E;
    endfunction

    function automatic dataWord_t mergeBytes(input dataWord_t old, input dataWord_t data,
                                             input logic [3:0] wm);
        dataWord_t res;
        for (int b = 0; b < 4; b++) begin
            res[b*8 +: 8] = wm[b] ? data[b*8 +: 8] : old[b*8 +: 8];
        end
        return res;
    endfunction

    function automatic instrWord_t fetchWord(input logic [8:0] row);
        return {expInstr[{row, 1'b1}], expInstr[{row, 1'b0}]};   // odd word on top
    endfunction

    task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED: %s got %h expected %h", name, got, exp);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    // busy run length and cycle count
    always @(posedge SPI_clk or negedge rstN) begin
        if (!rstN) begin
            cycleNo     <= 0;
            busyRun     <= 0;
            lastBusyRun <= 0;
        end else begin
            cycleNo <= cycleNo + 1;
            if (u_memSubsystem.busy) begin
                busyRun <= busyRun + 1;
            end else if (busyRun != 0) begin
                lastBusyRun <= busyRun;
                busyRun     <= 0;
            end
        end
    end

    always @(posedge SPI_clk) begin
        if (budget != 0 && cycleNo > budget) begin
            $display("timeout: run did not finish within %0d cycles", budget);
            $display("Some tests failed");
            $fatal(1);
        end
    end

    // core read compare, data is valid at the falling edge after the request edge
    always @(posedge SPI_clk or negedge rstN) begin
        if (!rstN) begin
            rdPend    <= 1'b0;
            fetchPend <= 1'b0;
        end else begin
            rdPend        <= coreRdEn;
            rdPendAddr    <= coreRdAddr;
            fetchPend     <= coreFetchEn;
            fetchPendAddr <= coreFetchAddr;
        end
    end

    always @(negedge SPI_clk) begin
        if (rdPend) begin
            checkValue($sformatf("coreRdData[%0d]", rdPendAddr), 64'(coreRdData),
                       64'(expData[rdPendAddr]));
        end
        if (fetchPend) begin
            checkValue($sformatf("coreFetchData[%0d]", fetchPendAddr), coreFetchData,
                       fetchWord(fetchPendAddr));
        end
    end

    task automatic nextCycle();
        @(posedge SPI_clk);
        #1;
    endtask

    task automatic axiWrite(input logic [3:0] addr, input logic [31:0] data, input int holdB,
                            output logic [1:0] resp);
        nextCycle();
        axiReq.awvalid = 1'b1;
        axiReq.awaddr  = addr;
        axiReq.wvalid  = 1'b1;
        axiReq.wdata   = data;
        axiReq.wstrb   = 4'hF;
        do begin
            @(posedge SPI_clk);
        end while (!axiRsp.awready);
        #1;
        axiReq.awvalid = 1'b0;
        axiReq.wvalid  = 1'b0;
        axiReq.bready  = (holdB == 0);
        do begin
            @(posedge SPI_clk);
        end while (!axiRsp.bvalid);
        resp = axiRsp.bresp;
        if (holdB > 0) begin
            for (int k = 1; k < holdB; k++) begin
                @(posedge SPI_clk);
                checkValue("bvalid", 64'(axiRsp.bvalid), 64'(1));
                checkValue("bresp", 64'(axiRsp.bresp), 64'(resp));
            end
            #1;
            axiReq.bready = 1'b1;
            @(posedge SPI_clk);
            checkValue("bvalid", 64'(axiRsp.bvalid), 64'(1));
        end
        #1;
        axiReq.bready = 1'b0;
    endtask

    task automatic axiRead(input logic [3:0] addr, input int holdR, output logic [31:0] data);
        nextCycle();
        axiReq.arvalid = 1'b1;
        axiReq.araddr  = addr;
        do begin
            @(posedge SPI_clk);
        end while (!axiRsp.arready);
        #1;
        axiReq.arvalid = 1'b0;
        axiReq.rready  = (holdR == 0);
        do begin
            @(posedge SPI_clk);
        end while (!axiRsp.rvalid);
        data = axiRsp.rdata;
        checkValue("rresp", 64'(axiRsp.rresp), 64'(respOkay));
        if (holdR > 0) begin
            for (int k = 1; k < holdR; k++) begin
                @(posedge SPI_clk);
                checkValue("rvalid", 64'(axiRsp.rvalid), 64'(1));
                checkValue("rdata", 64'(axiRsp.rdata), 64'(data));
            end
            #1;
            axiReq.rready = 1'b1;
            @(posedge SPI_clk);
            checkValue("rvalid", 64'(axiRsp.rvalid), 64'(1));
            checkValue("rdata", 64'(axiRsp.rdata), 64'(data));
        end
        #1;
        axiReq.rready = 1'b0;
    endtask

    task automatic writeExpect(input logic [3:0] addr, input logic [31:0] data,
                               input logic [1:0] expResp);
        logic [1:0] resp;
        axiWrite(addr, data, 0, resp);
        checkValue("bresp", 64'(resp), 64'(expResp));
    endtask

    task automatic programCmd(input logic [29:0] ext, input logic [9:0] sram, input int len);
        writeExpect(regExtAddr, 32'(ext), respOkay);
        writeExpect(regSramAddr, 32'(sram), respOkay);
        writeExpect(regLen, 32'(len), respOkay);
    endtask

    task automatic startCmd(input logic toExt, input logic cacheId, input logic [1:0] expResp);
        writeExpect(regCtrl, {29'b0, cacheId, toExt, 1'b1}, expResp);
    endtask

    task automatic finishTransfer(input int len);
        logic [31:0] status;
        do begin
            axiRead(regCtrl, 0, status);
        end while (status[ctrlBusy]);
        checkValue("busy cycles", 64'(lastBusyRun), 64'(len + 3));
        checkValue("progress", 64'(status[progressLsb +: 10]), 64'(10'(len)));
    endtask

    // expected effect of one transfer on the reference arrays
    task automatic modelTransfer(input logic [29:0] ext, input logic [9:0] sram, input int len,
                                 input logic toExt, input logic cacheId);
        logic [11:0] e;
        logic [9:0]  s;
        for (int i = 0; i < len; i++) begin
            e = 12'(ext + 30'(i));
            s = sram + 10'(i);
            if (toExt) begin
                expExt[e] = expData[s];
            end else if (cacheId) begin
                expInstr[s] = expExt[e];
            end else begin
                expData[s] = expExt[e];
            end
        end
    endtask

    task automatic runTransfer(input logic [29:0] ext, input logic [9:0] sram, input int len,
                               input logic toExt, input logic cacheId);
        programCmd(ext, sram, len);
        startCmd(toExt, cacheId, respOkay);
        finishTransfer(len);
        modelTransfer(ext, sram, len, toExt, cacheId);
    endtask

    task automatic coreWrite(input logic [9:0] addr, input dataWord_t data, input logic [3:0] wm);
        nextCycle();
        coreWr.ce   = 1'b1;
        coreWr.we   = 1'b1;
        coreWr.wm   = wm;
        coreWr.addr = 30'(addr);
        coreWr.data = data;
        nextCycle();
        coreWr = '0;
    endtask

    task automatic readDataRange(input logic [9:0] base, input int len);
        for (int i = 0; i < len; i++) begin
            nextCycle();
            coreRdEn   = 1'b1;
            coreRdAddr = base + 10'(i);
        end
        nextCycle();
        coreRdEn = 1'b0;
    endtask

    task automatic readFetchRange(input logic [8:0] base, input int rows);
        for (int i = 0; i < rows; i++) begin
            nextCycle();
            coreFetchEn   = 1'b1;
            coreFetchAddr = base + 9'(i);
        end
        nextCycle();
        coreFetchEn = 1'b0;
    endtask

    task automatic checkExtMem();
        for (int i = 0; i < extWords; i++) begin
            checkValue($sformatf("extMem[%0d]", i), 64'(u_extMem.mem[i]), 64'(expExt[i]));
        end
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] wv;
        logic [1:0]  resp;
        logic [9:0]  wa;
        logic [3:0]  wm;
        int          holdB;
        int          holdR;

        SPI_clk       = 1'b0;
        rstN          = 1'b0;
        axiReq        = '0;
        coreWr        = '0;
        coreRdEn      = 1'b0;
        coreRdAddr    = '0;
        coreFetchEn   = 1'b0;
        coreFetchAddr = '0;
        budget        = 0;

        void'($urandom(32'h48c20579));
        ext2  = 30'($urandom);
        sram2 = 10'($urandom);
        len2  = 1 + int'($urandom % 200);
        ext3  = 30'($urandom);
        len3  = 2 * (1 + int'($urandom % 100));
        sram3 = 10'(2 * ($urandom % ((dataDepth - len3) / 2 + 1)));   // keeps whole rows
        ext4  = 30'($urandom);
        ext5  = 30'($urandom);
        sram5 = 10'($urandom);
        len5  = 8 + int'($urandom % 64);
        budget = 2 * (len2 + 3) + (len3 + 3) + (len5 + 3) + 2000;

        for (int i = 0; i < extWords; i++) begin
            expExt[i] = extFill(i);
        end

        repeat (3) @(posedge SPI_clk);
        #1;
        rstN = 1'b1;

        // 1: reset state and register readback
        checkValue("extEn", 64'(extEn), 64'(0));
        checkValue("extOen", 64'(extOen), 64'(0));
        checkValue("awready", 64'(axiRsp.awready), 64'(0));
        checkValue("wready", 64'(axiRsp.wready), 64'(0));
        checkValue("bvalid", 64'(axiRsp.bvalid), 64'(0));
        checkValue("arready", 64'(axiRsp.arready), 64'(0));
        checkValue("rvalid", 64'(axiRsp.rvalid), 64'(0));
        axiRead(regCtrl, 0, rd);
        checkValue("busy", 64'(rd[ctrlBusy]), 64'(0));
        wv = $urandom;
        writeExpect(regExtAddr, wv, respOkay);
        axiRead(regExtAddr, 0, rd);
        checkValue("regExtAddr", 64'(rd), 64'(wv & 32'h3FFF_FFFF));
        wv = $urandom;
        writeExpect(regSramAddr, wv, respOkay);
        axiRead(regSramAddr, 0, rd);
        checkValue("regSramAddr", 64'(rd), 64'(wv & 32'h3FF));
        wv = $urandom;
        writeExpect(regLen, wv, respOkay);
        axiRead(regLen, 0, rd);
        checkValue("regLen", 64'(rd), 64'(wv & 32'h7FF));

        // 2: ext to data bank
        runTransfer(ext2, sram2, len2, 1'b0, 1'b0);
        readDataRange(sram2, len2);

        // 3: ext to instruction bank
        runTransfer(ext3, sram3, len3, 1'b0, 1'b1);
        readFetchRange(9'(sram3 >> 1), len3 / 2);

        // 4: masked core writes, then data bank to ext
        for (int n = 0; n < maskWrites; n++) begin
            wa = sram2 + 10'($urandom % len2);
            wv = $urandom;
            wm = 4'($urandom);
            coreWrite(wa, wv, wm);
            expData[wa] = mergeBytes(expData[wa], wv, wm);
        end
        readDataRange(sram2, len2);
        runTransfer(ext4, sram2, len2, 1'b1, 1'b0);
        checkExtMem();

        // 5: illegal starts
        programCmd(ext5, sram5, len5);
        startCmd(1'b0, 1'b0, respOkay);
        startCmd(1'b1, 1'b0, respSlvErr);            // while busy
        finishTransfer(len5);
        modelTransfer(ext5, sram5, len5, 1'b0, 1'b0);
        startCmd(1'b1, 1'b1, respSlvErr);
        axiRead(regCtrl, 0, rd);
        checkValue("busy", 64'(rd[ctrlBusy]), 64'(0));
        checkExtMem();
        readDataRange(sram5, len5);
        readFetchRange(9'(sram3 >> 1), len3 / 2);

        // 6: response hold under back-pressure
        wv    = $urandom;
        holdB = 1 + int'($urandom % 8);
        holdR = 1 + int'($urandom % 8);
        axiWrite(regSramAddr, wv, holdB, resp);
        checkValue("bresp", 64'(resp), 64'(respOkay));
        axiRead(regSramAddr, holdR, rd);
        checkValue("regSramAddr", 64'(rd), 64'(wv & 32'h3FF));

        repeat (2) @(posedge SPI_clk);
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== project.f ====
src/memPkg.sv
src/ctrlRegs.sv
src/transferFsm.sv
src/burstCounter.sv
src/sramBank.sv
src/memSubsystem.sv
test/extMemModel.sv
test/tbMemSubsystem.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tbMemSubsystem
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
